//--- Makefile
# Verilator build of the cache subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_cache
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the simulator status is ignored, the log decides pass or fail
run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^TESTS PASSED$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cache/cache_core.sv
// direct-mapped write-through cache core, serves load hits and starts refills on load misses
`timescale 1ns/1ns

module cache_core #(
    parameter int INDEX_WIDTH  = 6,
    parameter int OFFSET_WIDTH = 2
) (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_flush,
    // stage request port
    input  logic                                i_req_valid,
    input  logic                                i_req_wen_nren,
    input  cache_pkg::size_e                    i_req_size,
    input  logic [cache_pkg::PADDR_WIDTH-1:0]   i_req_addr,
    input  logic [cache_pkg::WORD_WIDTH-1:0]    i_req_wdata,
    output logic                                o_req_ready,
    output logic [cache_pkg::WORD_WIDTH-1:0]    o_req_rdata,
    // refill reads towards the arbiter
    output logic                                o_fill_valid,
    output logic [cache_pkg::PADDR_WIDTH-1:0]   o_fill_addr,
    input  logic                                i_fill_ready,
    input  logic [cache_pkg::WORD_WIDTH-1:0]    i_fill_rdata,
    // write-through stores towards the arbiter
    output logic                                o_st_valid,
    output logic [cache_pkg::PADDR_WIDTH-1:0]   o_st_addr,
    output logic [cache_pkg::WORD_WIDTH-1:0]    o_st_wdata,
    input  logic                                i_st_ready
);

    localparam int TAG_WIDTH   = cache_pkg::PADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;
    localparam int LINE_WORDS  = 2 ** OFFSET_WIDTH;
    localparam int CACHE_DEPTH = 2 ** INDEX_WIDTH;
    localparam int LINE_BITS   = LINE_WORDS * cache_pkg::WORD_WIDTH;

    // address fields, from the top: tag, index, word offset, byte offset
    logic [TAG_WIDTH-1:0]    req_tag;
    logic [INDEX_WIDTH-1:0]  req_index;
    logic [OFFSET_WIDTH-1:0] req_word;
    logic [1:0]              req_byte;
    assign req_tag   = i_req_addr[cache_pkg::PADDR_WIDTH-1 -: TAG_WIDTH];
    assign req_index = i_req_addr[OFFSET_WIDTH + 2 +: INDEX_WIDTH];
    assign req_word  = i_req_addr[2 +: OFFSET_WIDTH];
    assign req_byte  = i_req_addr[1:0];

    logic [CACHE_DEPTH-1:0]         line_valid_q;
    logic [TAG_WIDTH-1:0]           rd_tag;
    logic [LINE_BITS-1:0]           rd_line;
    logic [LINE_WORDS-1:0]          fill_wben;
    logic                           fill_word_wen;
    logic                           tag_wen;
    logic                           valid_set;
    logic                           refill_busy;
    logic                           present;
    logic                           load_req;
    logic                           store_req;
    logic                           hit;
    logic [cache_pkg::WORD_WIDTH-1:0] hit_word;

    assign load_req  = i_req_valid && !i_req_wen_nren;
    assign store_req = i_req_valid && i_req_wen_nren;

    // line holds the requested address
    assign present = line_valid_q[req_index] && (rd_tag == req_tag);

    // no hits while the refill owns the RAMs
    assign hit = load_req && present && !refill_busy;

    // valid bits live in flops so flush takes one cycle
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            line_valid_q <= '0;
        end else if (i_flush) begin
            line_valid_q <= '0;
        end else if (store_req && present) begin
            // store hit drops the line instead of patching it
            line_valid_q[req_index] <= 1'b0;
        end else if (valid_set) begin
            line_valid_q[req_index] <= 1'b1;
        end
    end

    // data words, one lane per word, written from memory beats
    lutram #(
        .DEPTH (CACHE_DEPTH),
        .DWIDTH(LINE_BITS),
        .BWIDTH(cache_pkg::WORD_WIDTH)
    ) data_ram_inst (
        .i_clk  (i_clk),
        .i_wen  (fill_word_wen),
        .i_waddr(req_index),
        .i_wben (fill_wben),
        .i_wdata({LINE_WORDS{i_fill_rdata}}),
        .i_raddr(req_index),
        .o_rdata(rd_line)
    );

    // tags, a single full-width lane
    lutram #(
        .DEPTH (CACHE_DEPTH),
        .DWIDTH(TAG_WIDTH),
        .BWIDTH(TAG_WIDTH)
    ) tag_ram_inst (
        .i_clk  (i_clk),
        .i_wen  (tag_wen),
        .i_waddr(req_index),
        .i_wben (1'b1),
        .i_wdata(req_tag),
        .i_raddr(req_index),
        .o_rdata(rd_tag)
    );

    // stage holds the address, so the refill writes under the same index
    line_refill #(
        .INDEX_WIDTH (INDEX_WIDTH),
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) line_refill_inst (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (load_req && !present && !refill_busy),
        .i_line_addr     ({i_req_addr[cache_pkg::PADDR_WIDTH-1:OFFSET_WIDTH+2],
                           {(OFFSET_WIDTH+2){1'b0}}}),
        .i_mem_ready     (i_fill_ready),
        .o_mem_valid     (o_fill_valid),
        .o_mem_addr      (o_fill_addr),
        .o_wben          (fill_wben),
        .o_word_wen      (fill_word_wen),
        .o_tag_wen       (tag_wen),
        .o_line_valid_set(valid_set),
        .o_busy          (refill_busy)
    );

    // pick the word, then move the addressed lane down to bit 0
    assign hit_word = rd_line[req_word*cache_pkg::WORD_WIDTH +: cache_pkg::WORD_WIDTH];

    always_comb begin
        case (i_req_size)
            cache_pkg::SIZE_BYTE:     o_req_rdata = {24'h0, hit_word[req_byte*8 +: 8]};
            cache_pkg::SIZE_HALFWORD: o_req_rdata = {16'h0, hit_word[req_byte[1]*16 +: 16]};
            cache_pkg::SIZE_WORD:     o_req_rdata = hit_word;
            default:                  o_req_rdata = '0;
        endcase
    end

    // stores pass straight through to memory
    assign o_st_valid = store_req;
    assign o_st_addr  = i_req_addr;
    assign o_st_wdata = i_req_wdata;

    // loads finish on a hit, stores on the memory write pulse
    assign o_req_ready = i_req_wen_nren ? i_st_ready : hit;

    // a completed load never returns X from an unwritten lane
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        load_req && o_req_ready |-> !$isunknown(o_req_rdata))
        else $error("load completed with unknown data");

    // halfwords are naturally aligned
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_req_valid && (i_req_size == cache_pkg::SIZE_HALFWORD) |-> !i_req_addr[0])
        else $error("misaligned halfword access");

    // arbiter only returns refill beats while the refill is fetching
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_fill_ready |-> (line_refill_inst.state == cache_pkg::REFILL_FILL))
        else $error("refill ready outside fill state");

endmodule

//--- cache/line_refill.sv
// line refill FSM, walks the line address and steers one data word per memory beat into the cache
`timescale 1ns/1ns

module line_refill #(
    parameter int INDEX_WIDTH  = 6,
    parameter int OFFSET_WIDTH = 2,
    localparam int LINE_WORDS  = 2 ** OFFSET_WIDTH
) (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_start,
    input  logic [cache_pkg::PADDR_WIDTH-1:0]   i_line_addr,
    input  logic                                i_mem_ready,
    output logic                                o_mem_valid,
    output logic [cache_pkg::PADDR_WIDTH-1:0]   o_mem_addr,
    output logic [LINE_WORDS-1:0]               o_wben,
    output logic                                o_word_wen,
    output logic                                o_tag_wen,
    output logic                                o_line_valid_set,
    output logic                                o_busy
);

    // bit positions of the index field within an address
    localparam int INDEX_LSB = OFFSET_WIDTH + 2;
    localparam int INDEX_MSB = INDEX_LSB + INDEX_WIDTH - 1;

    // byte step between consecutive words of a line
    localparam logic [cache_pkg::PADDR_WIDTH-1:0] WORD_STEP = 4;

    cache_pkg::refill_state_e state;
    cache_pkg::refill_state_e state_next;

    // burst address counter
    logic [cache_pkg::PADDR_WIDTH-1:0] addr_q;

    // one-hot enable of the word being fetched
    logic [LINE_WORDS-1:0] wben_q;

    // beat accepted by memory this cycle
    logic beat_done;
    assign beat_done = (state == cache_pkg::REFILL_FILL) && i_mem_ready;

    // next state
    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::REFILL_IDLE: begin
                if (i_start) begin
                    state_next = cache_pkg::REFILL_FILL;
                end
            end
            cache_pkg::REFILL_FILL: begin
                // last word enable set means this beat completes the line
                if (beat_done && wben_q[LINE_WORDS-1]) begin
                    state_next = cache_pkg::REFILL_WRITE_TAG;
                end
            end
            cache_pkg::REFILL_WRITE_TAG: begin
                state_next = cache_pkg::REFILL_IDLE;
            end
            default: begin
                state_next = cache_pkg::REFILL_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= cache_pkg::REFILL_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // counter and shifter load on start, then advance once per beat
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            addr_q <= i_line_addr;
            wben_q <= LINE_WORDS'(1);
        end else if (beat_done) begin
            addr_q <= addr_q + WORD_STEP;
            wben_q <= wben_q << 1;
        end
    end

    // memory request is held for the whole fill
    assign o_mem_valid = (state == cache_pkg::REFILL_FILL);
    assign o_mem_addr  = addr_q;

    // data RAM lanes follow the shifter, written only on a completed beat
    assign o_wben     = wben_q;
    assign o_word_wen = beat_done;

    // tag and valid bit are committed together after the last word
    assign o_tag_wen        = (state == cache_pkg::REFILL_WRITE_TAG);
    assign o_line_valid_set = (state == cache_pkg::REFILL_WRITE_TAG);
    assign o_busy           = (state != cache_pkg::REFILL_IDLE);

    // exactly one word lane is targeted while filling
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state == cache_pkg::REFILL_FILL) |-> $onehot(o_wben))
        else $error("refill word enable not one-hot");

    // the core must not request a new refill while one is running
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_start |-> (state == cache_pkg::REFILL_IDLE))
        else $error("refill start outside idle");

    // the burst never walks out of the line into the next index
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state == cache_pkg::REFILL_FILL) && $past(state == cache_pkg::REFILL_FILL)
        |-> $stable(o_mem_addr[INDEX_MSB:INDEX_LSB]))
        else $error("refill address crossed a line boundary");

endmodule

//--- common/cache_pkg.sv
// shared widths and enums for the cache subsystem, referenced by scoped name from every RTL file
package cache_pkg;

    // physical address width in bits
    localparam int PADDR_WIDTH = 32;

    // width of one data word, also the memory beat width
    localparam int WORD_WIDTH = 32;

    // access size carried on the stage request port
    typedef enum logic [1:0] {
        SIZE_BYTE     = 2'd0,
        SIZE_HALFWORD = 2'd1,
        SIZE_WORD     = 2'd2
    } size_e;

    // line refill FSM states
    // idle waits for a load miss
    // fill runs one memory beat per line word
    // write_tag commits the tag and sets the valid bit
    typedef enum logic [1:0] {
        REFILL_IDLE      = 2'd0,
        REFILL_FILL      = 2'd1,
        REFILL_WRITE_TAG = 2'd2
    } refill_state_e;

endpackage

//--- list.f
common/cache_pkg.sv
src/lutram.sv
cache/line_refill.sv
cache/cache_core.sv
src/mem_arbiter.sv
src/cache_subsystem_top.sv
test/mem_model.sv
test/tb_cache.sv

//--- src/cache_subsystem_top.sv
// cache subsystem top, joins the cache core to the memory arbiter and exposes stage and memory ports
`timescale 1ns/1ns

module cache_subsystem_top #(
    parameter int INDEX_WIDTH  = 6,
    parameter int OFFSET_WIDTH = 2
) (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_flush,
    // stage request port
    input  logic                                i_req_valid,
    input  logic                                i_req_wen_nren,
    input  cache_pkg::size_e                    i_req_size,
    input  logic [cache_pkg::PADDR_WIDTH-1:0]   i_req_addr,
    input  logic [cache_pkg::WORD_WIDTH-1:0]    i_req_wdata,
    output logic                                o_req_ready,
    output logic [cache_pkg::WORD_WIDTH-1:0]    o_req_rdata,
    // memory port
    output logic                                o_mem_valid,
    output logic                                o_mem_wen_nren,
    output logic [cache_pkg::PADDR_WIDTH-1:0]   o_mem_addr,
    output logic [cache_pkg::WORD_WIDTH-1:0]    o_mem_wdata,
    input  logic                                i_mem_ready,
    input  logic [cache_pkg::WORD_WIDTH-1:0]    i_mem_rdata
);

    // refill path between core and arbiter
    logic                              fill_valid;
    logic [cache_pkg::PADDR_WIDTH-1:0] fill_addr;
    logic                              fill_ready;
    logic [cache_pkg::WORD_WIDTH-1:0]  fill_rdata;

    // store path between core and arbiter
    logic                              st_valid;
    logic [cache_pkg::PADDR_WIDTH-1:0] st_addr;
    logic [cache_pkg::WORD_WIDTH-1:0]  st_wdata;
    logic                              st_ready;

    cache_core #(
        .INDEX_WIDTH (INDEX_WIDTH),
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) cache_core_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_req_valid(i_req_valid), .i_req_wen_nren(i_req_wen_nren), .i_req_size(i_req_size),
        .i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata),
        .o_req_ready(o_req_ready), .o_req_rdata(o_req_rdata),
        .o_fill_valid(fill_valid), .o_fill_addr(fill_addr),
        .i_fill_ready(fill_ready), .i_fill_rdata(fill_rdata),
        .o_st_valid(st_valid), .o_st_addr(st_addr), .o_st_wdata(st_wdata),
        .i_st_ready(st_ready)
    );

    mem_arbiter mem_arbiter_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_fill_valid(fill_valid), .i_fill_addr(fill_addr),
        .o_fill_ready(fill_ready), .o_fill_rdata(fill_rdata),
        .i_st_valid(st_valid), .i_st_addr(st_addr), .i_st_wdata(st_wdata),
        .o_st_ready(st_ready),
        .o_mem_valid(o_mem_valid), .o_mem_wen_nren(o_mem_wen_nren),
        .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata),
        .i_mem_ready(i_mem_ready), .i_mem_rdata(i_mem_rdata)
    );

endmodule

//--- src/lutram.sv
// distributed RAM with lane write enables and asynchronous read, used for cache data and tags
`timescale 1ns/1ns

module lutram #(
    parameter int DEPTH  = 64,
    parameter int DWIDTH = 128,
    parameter int BWIDTH = 32,
    localparam int AWIDTH = $clog2(DEPTH),
    localparam int LANES  = DWIDTH / BWIDTH
) (
    input  logic              i_clk,
    input  logic              i_wen,
    input  logic [AWIDTH-1:0] i_waddr,
    input  logic [LANES-1:0]  i_wben,
    input  logic [DWIDTH-1:0] i_wdata,
    input  logic [AWIDTH-1:0] i_raddr,
    output logic [DWIDTH-1:0] o_rdata
);

    // storage array, contents undefined until written
    logic [DWIDTH-1:0] mem [DEPTH];

    // write port, each lane only changes when its enable is set
    always_ff @(posedge i_clk) begin
        if (i_wen) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (i_wben[lane]) begin
                    mem[i_waddr][lane*BWIDTH +: BWIDTH] <= i_wdata[lane*BWIDTH +: BWIDTH];
                end
            end
        end
    end

    // read port is combinational so a hit resolves in the request cycle
    assign o_rdata = mem[i_raddr];

    // a write with no lane selected would be a lost beat
    assert property (@(posedge i_clk) i_wen |-> (i_wben != '0))
        else $error("lutram write with empty lane mask");

endmodule

//--- src/mem_arbiter.sv
// memory port arbiter, merges refill reads and write-through stores and keeps each beat on one owner
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    // refill reads
    input  logic                                i_fill_valid,
    input  logic [cache_pkg::PADDR_WIDTH-1:0]   i_fill_addr,
    output logic                                o_fill_ready,
    output logic [cache_pkg::WORD_WIDTH-1:0]    o_fill_rdata,
    // stores
    input  logic                                i_st_valid,
    input  logic [cache_pkg::PADDR_WIDTH-1:0]   i_st_addr,
    input  logic [cache_pkg::WORD_WIDTH-1:0]    i_st_wdata,
    output logic                                o_st_ready,
    // memory port
    output logic                                o_mem_valid,
    output logic                                o_mem_wen_nren,
    output logic [cache_pkg::PADDR_WIDTH-1:0]   o_mem_addr,
    output logic [cache_pkg::WORD_WIDTH-1:0]    o_mem_wdata,
    input  logic                                i_mem_ready,
    input  logic [cache_pkg::WORD_WIDTH-1:0]    i_mem_rdata
);

    typedef enum logic {
        OWNER_FILL  = 1'b0,
        OWNER_STORE = 1'b1
    } owner_e;

    owner_e owner_q;
    logic   beat_open_q;
    logic   sel_store;

    // open beat keeps its owner, otherwise refill wins
    assign sel_store = beat_open_q ? (owner_q == OWNER_STORE) : !i_fill_valid;

    assign o_mem_valid    = sel_store ? i_st_valid : i_fill_valid;
    assign o_mem_wen_nren = sel_store;
    assign o_mem_addr     = sel_store ? i_st_addr : i_fill_addr;
    assign o_mem_wdata    = i_st_wdata;

    // ready goes back to the owner only
    assign o_fill_ready = i_mem_ready && !sel_store;
    assign o_st_ready   = i_mem_ready && sel_store;
    assign o_fill_rdata = i_mem_rdata;

    // remember the owner of a beat still waiting on ready
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            beat_open_q <= 1'b0;
            owner_q     <= OWNER_FILL;
        end else if (o_mem_valid && !i_mem_ready) begin
            beat_open_q <= 1'b1;
            owner_q     <= sel_store ? OWNER_STORE : OWNER_FILL;
        end else if (i_mem_ready) begin
            beat_open_q <= 1'b0;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n) i_mem_ready |-> o_mem_valid)
        else $error("memory ready without a request");

endmodule

//--- test/mem_model.sv
// behavioral word memory for the testbench, answers each beat after a random number of cycles
`timescale 1ns/1ns

module mem_model #(
    parameter logic [31:0] FILL_KEY  = 32'h5a3c_96e1,
    parameter int          MAX_DELAY = 3
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_valid,
    input  logic        i_wen_nren,
    input  logic [31:0] i_addr,
    input  logic [31:0] i_wdata,
    output logic        o_ready,
    output logic [31:0] o_rdata
);

    // words written by stores, everything else reads the fill pattern
    logic [31:0] shadow [logic [31:0]];

    // seed for the ready delay
    integer seed = 32'h73e9_a0d1;

    logic        busy;
    int          wait_cnt;
    logic [31:0] word_addr;

    assign word_addr = {i_addr[31:2], 2'b00};

    // unwritten words are the address mixed with a key
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr ^ FILL_KEY;
    endfunction

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy     <= 1'b0;
            wait_cnt <= 0;
            o_ready  <= 1'b0;
            o_rdata  <= '0;
        end else if (o_ready) begin
            // beat completes at this edge, a write lands in the shadow now
            if (i_wen_nren) begin
                shadow[word_addr] = i_wdata;
            end
            o_ready <= 1'b0;
        end else if (i_valid) begin
            if (!busy) begin
                // new beat, draw how long to stall it
                busy     <= 1'b1;
                wait_cnt <= {$random(seed)} % (MAX_DELAY + 1);
            end else if (wait_cnt == 0) begin
                busy    <= 1'b0;
                o_ready <= 1'b1;
                o_rdata <= read_word(word_addr);
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

//--- test/tb_cache.sv
// testbench top for the cache subsystem, runs directed loads, stores and flushes against a memory model
`timescale 1ns/1ns

module tb_cache;

    localparam int          INDEX_WIDTH  = 6;
    localparam int          OFFSET_WIDTH = 2;
    localparam int          LINE_WORDS   = 2 ** OFFSET_WIDTH;
    localparam logic [31:0] FILL_KEY     = 32'h5a3c_96e1;
    // 7 refills of a full line plus 2 stores
    localparam int          MEM_BEATS      = 7 * LINE_WORDS + 2;
    localparam int          TIMEOUT_CYCLES = 20 * MEM_BEATS + 2000;

    logic             i_clk = 1'b0;
    logic             i_rst_n;
    logic             i_flush;
    logic             i_req_valid;
    logic             i_req_wen_nren;
    cache_pkg::size_e i_req_size;
    logic [31:0]      i_req_addr;
    logic [31:0]      i_req_wdata;
    logic             o_req_ready;
    logic [31:0]      o_req_rdata;
    logic             o_mem_valid;
    logic             o_mem_wen_nren;
    logic [31:0]      o_mem_addr;
    logic [31:0]      o_mem_wdata;
    logic             i_mem_ready;
    logic [31:0]      i_mem_rdata;

    // expectations for the request in flight
    logic        load_active;
    logic        store_active;
    logic [31:0] exp_rdata;
    logic [31:0] exp_st_addr;
    logic [31:0] exp_st_data;
    logic [31:0] line_base;
    int          exp_beats;
    int          read_beats;
    int          cycle_count = 0;

    // reference memory, holds only words written by stores
    logic [31:0] ref_mem [logic [31:0]];

    always #2 i_clk = ~i_clk;

    cache_subsystem_top #(
        .INDEX_WIDTH (INDEX_WIDTH),
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) cache_subsystem_top_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_req_valid(i_req_valid), .i_req_wen_nren(i_req_wen_nren), .i_req_size(i_req_size),
        .i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata),
        .o_req_ready(o_req_ready), .o_req_rdata(o_req_rdata),
        .o_mem_valid(o_mem_valid), .o_mem_wen_nren(o_mem_wen_nren),
        .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata),
        .i_mem_ready(i_mem_ready), .i_mem_rdata(i_mem_rdata)
    );

    mem_model #(
        .FILL_KEY(FILL_KEY)
    ) mem_model_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(o_mem_valid),
        .i_wen_nren(o_mem_wen_nren), .i_addr(o_mem_addr), .i_wdata(o_mem_wdata),
        .o_ready(i_mem_ready), .o_rdata(i_mem_rdata)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // memory word as the rules define it
    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [31:0] aligned;
        aligned = {addr[31:2], 2'b00};
        if (ref_mem.exists(aligned)) begin
            return ref_mem[aligned];
        end
        return aligned ^ FILL_KEY;
    endfunction

    // addressed lane moved down to bit 0, upper bits zero
    function automatic logic [31:0] expect_load(input logic [31:0] addr,
                                                input cache_pkg::size_e size);
        logic [31:0] shifted;
        shifted = model_word(addr) >> (addr[1:0] * 8);
        case (size)
            cache_pkg::SIZE_BYTE:     return shifted & 32'h0000_00ff;
            cache_pkg::SIZE_HALFWORD: return shifted & 32'h0000_ffff;
            default:                  return shifted;
        endcase
    endfunction

    // count refill reads of the current load, cleared between requests
    always @(posedge i_clk) begin
        if (!load_active) begin
            read_beats <= 0;
        end else if (o_mem_valid && i_mem_ready && !o_mem_wen_nren) begin
            read_beats <= read_beats + 1;
        end
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("timeout: a request never completed within the cycle limit");
        end
    end

    a_load_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        load_active && o_req_ready |-> o_req_rdata == exp_rdata)
        else fail_run($sformatf("Fail o_req_rdata exp %h got %h", exp_rdata, o_req_rdata));

    // refill reads walk the line upwards from its first word
    a_fill_addr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        load_active && o_mem_valid && i_mem_ready && !o_mem_wen_nren
        |-> o_mem_addr == line_base + 32'(read_beats * 4))
        else fail_run($sformatf("Fail o_mem_addr exp %h got %h",
                                line_base + 32'(read_beats * 4), o_mem_addr));

    a_beat_count: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        load_active && o_req_ready |-> read_beats == exp_beats)
        else fail_run($sformatf("Fail read beat count exp %h got %h", exp_beats, read_beats));

    // a hit answers in the request cycle and leaves memory idle
    a_hit_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        load_active && exp_beats == 0 |-> o_req_ready)
        else fail_run($sformatf("Fail o_req_ready exp %h got %h", 1'b1, o_req_ready));

    // no refill may start behind a hit
    a_hit_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        load_active && exp_beats == 0 |=> !o_mem_valid)
        else fail_run($sformatf("Fail o_mem_valid exp %h got %h", 1'b0, o_mem_valid));

    a_store_wen: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        store_active && o_mem_valid |-> o_mem_wen_nren)
        else fail_run($sformatf("Fail o_mem_wen_nren exp %h got %h", 1'b1, o_mem_wen_nren));

    a_store_addr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        store_active && o_mem_valid |-> o_mem_addr == exp_st_addr)
        else fail_run($sformatf("Fail o_mem_addr exp %h got %h", exp_st_addr, o_mem_addr));

    a_store_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        store_active && o_mem_valid |-> o_mem_wdata == exp_st_data)
        else fail_run($sformatf("Fail o_mem_wdata exp %h got %h", exp_st_data, o_mem_wdata));

    // ready is looked at on the falling edge, the handshake is the next rising edge
    task automatic wait_ready();
        do begin
            @(negedge i_clk);
        end while (!o_req_ready);
        @(posedge i_clk);
        #1;
    endtask

    // drop the request and leave one idle cycle
    task automatic end_request();
        i_req_valid  = 1'b0;
        load_active  = 1'b0;
        store_active = 1'b0;
        @(posedge i_clk);
        #1;
    endtask

    task automatic do_load(input logic [31:0] addr, input cache_pkg::size_e size,
                           input bit miss);
        i_req_valid    = 1'b1;
        i_req_wen_nren = 1'b0;
        i_req_size     = size;
        i_req_addr     = addr;
        exp_rdata      = expect_load(addr, size);
        exp_beats      = miss ? LINE_WORDS : 0;
        // first byte of the line, a line spans LINE_WORDS words of 4 bytes
        line_base      = addr & ~(32'(LINE_WORDS) * 32'd4 - 32'd1);
        load_active    = 1'b1;
        wait_ready();
        end_request();
    endtask

    task automatic do_store(input logic [31:0] addr, input logic [31:0] data);
        i_req_valid    = 1'b1;
        i_req_wen_nren = 1'b1;
        i_req_size     = cache_pkg::SIZE_WORD;
        i_req_addr     = addr;
        i_req_wdata    = data;
        exp_st_addr    = addr;
        exp_st_data    = data;
        store_active   = 1'b1;
        wait_ready();
        ref_mem[{addr[31:2], 2'b00}] = data;
        end_request();
    endtask

    task automatic do_flush();
        i_flush = 1'b1;
        @(posedge i_clk);
        #1;
        i_flush = 1'b0;
    endtask

    initial begin
        i_rst_n        = 1'b0;
        i_flush        = 1'b0;
        i_req_valid    = 1'b0;
        i_req_wen_nren = 1'b0;
        i_req_size     = cache_pkg::SIZE_WORD;
        i_req_addr     = '0;
        i_req_wdata    = '0;
        load_active    = 1'b0;
        store_active   = 1'b0;
        exp_rdata      = '0;
        exp_st_addr    = '0;
        exp_st_data    = '0;
        line_base      = '0;
        exp_beats      = 0;
        repeat (10) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        @(posedge i_clk);
        #1;
        // cold miss, then hits on the same line at every lane
        do_load(32'h0000_1000, cache_pkg::SIZE_WORD, 1'b1);
        do_load(32'h0000_1004, cache_pkg::SIZE_WORD, 1'b0);
        for (int b = 0; b < 4; b++) begin
            do_load(32'h0000_1008 + b, cache_pkg::SIZE_BYTE, 1'b0);
        end
        do_load(32'h0000_100c, cache_pkg::SIZE_HALFWORD, 1'b0);
        do_load(32'h0000_100e, cache_pkg::SIZE_HALFWORD, 1'b0);
        // store hit drops the line, the reload sees the new word
        do_store(32'h0000_1004, 32'hcafe_f00d);
        do_load(32'h0000_1004, cache_pkg::SIZE_WORD, 1'b1);
        do_load(32'h0000_1006, cache_pkg::SIZE_HALFWORD, 1'b0);
        // store to a line that was never cached
        do_store(32'h2000_0040, 32'h1234_5678);
        do_load(32'h2000_0040, cache_pkg::SIZE_WORD, 1'b1);
        do_load(32'h2000_0043, cache_pkg::SIZE_BYTE, 1'b0);
        // flush forces the next load back to memory
        do_load(32'h0000_1000, cache_pkg::SIZE_WORD, 1'b0);
        do_flush();
        do_load(32'h0000_1000, cache_pkg::SIZE_WORD, 1'b1);
        // same index with another tag evicts in both directions
        do_load(32'h0000_1400, cache_pkg::SIZE_WORD, 1'b1);
        do_load(32'h0000_1000, cache_pkg::SIZE_WORD, 1'b1);
        do_load(32'h0000_1408, cache_pkg::SIZE_WORD, 1'b1);
        do_load(32'h0000_140c, cache_pkg::SIZE_WORD, 1'b0);
        $display("TESTS PASSED");
        $finish;
    end

endmodule
